//--- pmem_pkg.sv
`default_nettype none

package pmem_pkg;

	// four line interfaces, each an input and an output
	localparam int num_ports = 4;

	typedef logic [63:0] word_t;

	// address within one input's 4096 word buffer
	typedef logic [11:0] buf_addr_t;

	// per input packet tag, wraps at 64
	typedef logic [5:0] tag_t;

	// packet length in words, 1 to 63
	typedef logic [5:0] len_t;

	typedef logic [1:0] port_t;

	// result from the classifier
	typedef logic [9:0] match_t;

	// read command holding source port, start address and length
	typedef logic [19:0] cmd_t;

	// match result layout
	localparam int match_tag_lsb = 0;
	localparam int match_tag_msb = 5;
	localparam int match_src_lsb = 6;
	localparam int match_src_msb = 7;
	localparam int match_dst_lsb = 8;
	localparam int match_dst_msb = 9;

	// src and start address together form the global read address
	localparam int cmd_len_lsb = 0;
	localparam int cmd_addr_lsb = 6;
	localparam int cmd_src_lsb = 18;

endpackage

`default_nettype wire

//--- pkt_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pkt_stream_if import pmem_pkg::*; ();

	word_t data;
	logic valid;
	logic sop;
	logic eop;
	logic ready;

	// transmitter side of a stream
	modport source (
		output data,
		output valid,
		output sop,
		output eop,
		input ready
	);

	// receiver side, owns ready
	modport sink (
		input data,
		input valid,
		input sop,
		input eop,
		output ready
	);

endinterface

`default_nettype wire

//--- pkt_buffer_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_buffer_ram import pmem_pkg::*; (
	input logic clock,
	input logic wr_en,
	input buf_addr_t wr_addr,
	input word_t wr_data,
	input buf_addr_t rd_addr [num_ports],
	output word_t rd_data [num_ports]
);

	localparam int buf_words = 1 << $bits(buf_addr_t);

	// one replica per output so every output port reads on its own
	for (genvar o = 0; o < num_ports; o++) begin : g_replica
		word_t mem [buf_words];

		always_ff @(posedge clock) begin
			if (wr_en) begin
				mem[wr_addr] <= wr_data;
			end
		end

		// registered read, one cycle of latency
		always_ff @(posedge clock) begin
			rd_data[o] <= mem[rd_addr[o]];
		end
	end

endmodule

`default_nettype wire

//--- ingress_port.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_port import pmem_pkg::*; #(
	parameter port_t port_id = '0
) (
	input logic clock,
	input logic reset,
	pkt_stream_if.sink pkt_in,
	output logic buf_wr_en,
	output buf_addr_t buf_wr_addr,
	output tag_t tag,
	input tag_t lookup_tag,
	output cmd_t lookup_cmd
);

	localparam int table_depth = 1 << $bits(tag_t);

	logic fire;
	logic in_pkt;
	buf_addr_t wr_addr;
	buf_addr_t start_addr;
	buf_addr_t cur_start;
	len_t len_cnt;
	len_t cur_len;
	buf_addr_t tbl_addr [table_depth];
	len_t tbl_len [table_depth];

	assign fire = pkt_in.valid && pkt_in.ready;

	// a one word packet starts and ends on the same beat
	assign cur_start = pkt_in.sop ? wr_addr : start_addr;
	assign cur_len = pkt_in.sop ? len_t'(1) : len_cnt + len_t'(1);

	assign buf_wr_en = fire;
	assign buf_wr_addr = wr_addr;

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_addr <= '0;
			len_cnt <= '0;
			tag <= '0;
			in_pkt <= 1'b0;
		end else if (fire) begin
			wr_addr <= wr_addr + buf_addr_t'(1);
			len_cnt <= pkt_in.eop ? len_t'(0) : cur_len;
			in_pkt <= !pkt_in.eop;
			if (pkt_in.eop) begin
				tag <= tag + tag_t'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fire && pkt_in.sop) begin
			start_addr <= wr_addr;
		end
	end

	// table entry written under the tag the packet carried
	always_ff @(posedge clock) begin
		if (fire && pkt_in.eop) begin
			tbl_addr[tag] <= cur_start;
			tbl_len[tag] <= cur_len;
		end
	end

	assign lookup_cmd = {port_id, tbl_addr[lookup_tag], tbl_len[lookup_tag]};

	// after an eop the next transferred beat opens a new packet
	first_beat_is_sop: assert property (@(posedge clock) disable iff (reset)
		fire && !in_pkt |-> pkt_in.sop);

endmodule

`default_nettype wire

//--- cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_queue import pmem_pkg::*; #(
	parameter int cmdq_depth = 16
) (
	input logic clock,
	input logic reset,
	input logic push,
	input cmd_t push_cmd,
	input logic pop,
	output cmd_t head,
	output logic empty,
	output logic almost_full
);

	localparam int ptr_w = $clog2(cmdq_depth);
	localparam logic [ptr_w:0] full_level = (ptr_w + 1)'(cmdq_depth);

	cmd_t mem [cmdq_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic full;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// show-ahead head, valid whenever not empty
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == full_level);

	// one slot kept for the command still in the match pipeline
	assign almost_full = (count >= full_level - 1'b1);

	no_push_when_full: assert property (@(posedge clock) disable iff (reset)
		full |-> !push);

	no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
		empty |-> !pop);

endmodule

`default_nettype wire

//--- egress_port.sv
`timescale 1ns/1ps
`default_nettype none

module egress_port import pmem_pkg::*; (
	input logic clock,
	input logic reset,
	input cmd_t head,
	input logic empty,
	output logic pop,
	output buf_addr_t rd_addr,
	output port_t rd_src,
	input word_t rd_data [num_ports],
	pkt_stream_if.source tx
);

	typedef enum logic {
		st_idle,
		st_busy
	} state_t;

	state_t state;
	buf_addr_t addr_q;
	port_t src_q;
	len_t remain;
	logic first_q;
	logic rd_vld;
	logic tx_free;
	logic capture;
	logic last_word;

	assign pop = (state == st_idle) && !empty;
	assign tx_free = !tx.valid || tx.ready;

	// rd_vld means the buffer output holds the word at addr_q
	assign capture = (state == st_busy) && rd_vld && tx_free;
	assign last_word = (remain == len_t'(1));

	// a stalled word is simply read again from the same address
	assign rd_addr = capture ? addr_q + buf_addr_t'(1) : addr_q;
	assign rd_src = src_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			remain <= '0;
			first_q <= 1'b0;
			rd_vld <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (!empty) begin
						state <= st_busy;
						remain <= head[cmd_len_lsb +: $bits(len_t)];
						first_q <= 1'b1;
						rd_vld <= 1'b0;
					end
				end
				st_busy: begin
					if (capture) begin
						remain <= remain - len_t'(1);
						first_q <= 1'b0;
						rd_vld <= !last_word;
						if (last_word) begin
							state <= st_idle;
						end
					end else begin
						rd_vld <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			addr_q <= head[cmd_addr_lsb +: $bits(buf_addr_t)];
			src_q <= head[cmd_src_lsb +: $bits(port_t)];
		end else if (capture) begin
			addr_q <= rd_addr;
		end
	end

	// transmit holding register
	always_ff @(posedge clock) begin
		if (reset) begin
			tx.valid <= 1'b0;
			tx.sop <= 1'b0;
			tx.eop <= 1'b0;
		end else if (capture) begin
			tx.valid <= 1'b1;
			tx.sop <= first_q;
			tx.eop <= last_word;
		end else if (tx.ready) begin
			tx.valid <= 1'b0;
			tx.sop <= 1'b0;
			tx.eop <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			tx.data <= rd_data[src_q];
		end
	end

	tx_hold_stable: assert property (@(posedge clock) disable iff (reset)
		tx.valid && !tx.ready |=> tx.valid && $stable(tx.data) && $stable(tx.sop)
			&& $stable(tx.eop));

endmodule

`default_nettype wire

//--- pmem_group.sv
`timescale 1ns/1ps
`default_nettype none

module pmem_group import pmem_pkg::*; #(
	parameter int cmdq_depth = 16
) (
	input logic clock,
	input logic reset,

	// streams from the line interfaces
	input word_t packetin_data [num_ports],
	input logic packetin_valid [num_ports],
	input logic packetin_sop [num_ports],
	input logic packetin_eop [num_ports],
	output logic packetin_ready [num_ports],

	// same streams towards the classifier, with the tag
	output word_t packetout_data [num_ports],
	output logic packetout_valid [num_ports],
	output logic packetout_sop [num_ports],
	output logic packetout_eop [num_ports],
	input logic packetout_ready [num_ports],
	output tag_t packetout_channel [num_ports],

	// replayed packets
	output word_t transmitout_data [num_ports],
	output logic transmitout_valid [num_ports],
	output logic transmitout_sop [num_ports],
	output logic transmitout_eop [num_ports],
	input logic transmitout_ready [num_ports],

	// match results from the classifier
	input match_t tagin_data,
	input logic tagin_valid,
	output logic tagin_ready
);

	logic [num_ports-1:0] wr_en;
	logic [num_ports-1:0] q_push;
	logic [num_ports-1:0] q_pop;
	logic [num_ports-1:0] q_empty;
	logic [num_ports-1:0] q_afull;
	buf_addr_t wr_addr [num_ports];
	cmd_t lookup_cmd [num_ports];
	cmd_t q_head [num_ports];
	buf_addr_t eg_rd_addr [num_ports];
	port_t eg_rd_src [num_ports];
	buf_addr_t ram_rd_addr [num_ports][num_ports];
	word_t ram_rd_data [num_ports][num_ports];
	word_t eg_rd_data [num_ports][num_ports];

	logic tagin_accept;
	logic match_vld;
	match_t match_q;
	tag_t match_tag;
	port_t match_src;
	port_t match_dst;
	cmd_t push_cmd;

	// any queue near full stalls the classifier
	assign tagin_ready = ~|q_afull;
	assign tagin_accept = tagin_valid && tagin_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			match_vld <= 1'b0;
		end else begin
			match_vld <= tagin_accept;
		end
	end

	always_ff @(posedge clock) begin
		if (tagin_accept) begin
			match_q <= tagin_data;
		end
	end

	assign match_tag = match_q[match_tag_msb:match_tag_lsb];
	assign match_src = match_q[match_src_msb:match_src_lsb];
	assign match_dst = match_q[match_dst_msb:match_dst_lsb];

	// table entry of the source input goes to the destination queue
	assign push_cmd = lookup_cmd[match_src];

	for (genvar i = 0; i < num_ports; i++) begin : g_port
		pkt_stream_if rx_if ();
		pkt_stream_if tx_if ();

		assign rx_if.data = packetin_data[i];
		assign rx_if.valid = packetin_valid[i];
		assign rx_if.sop = packetin_sop[i];
		assign rx_if.eop = packetin_eop[i];
		assign rx_if.ready = packetout_ready[i];

		assign packetin_ready[i] = rx_if.ready;
		assign packetout_data[i] = rx_if.data;
		assign packetout_valid[i] = rx_if.valid;
		assign packetout_sop[i] = rx_if.sop;
		assign packetout_eop[i] = rx_if.eop;

		assign tx_if.ready = transmitout_ready[i];
		assign transmitout_data[i] = tx_if.data;
		assign transmitout_valid[i] = tx_if.valid;
		assign transmitout_sop[i] = tx_if.sop;
		assign transmitout_eop[i] = tx_if.eop;

		assign q_push[i] = match_vld && (match_dst == port_t'(i));

		// i is the input here, j the output
		for (genvar j = 0; j < num_ports; j++) begin : g_xbar
			// only the source buffer of output j follows its address
			assign ram_rd_addr[i][j] = (eg_rd_src[j] == port_t'(i)) ? eg_rd_addr[j] : '0;
			assign eg_rd_data[j][i] = ram_rd_data[i][j];
		end

		ingress_port #(
			.port_id(port_t'(i))
		) u_ingress (
			.clock(clock),
			.reset(reset),
			.pkt_in(rx_if),
			.buf_wr_en(wr_en[i]),
			.buf_wr_addr(wr_addr[i]),
			.tag(packetout_channel[i]),
			.lookup_tag(match_tag),
			.lookup_cmd(lookup_cmd[i])
		);

		pkt_buffer_ram u_ram (
			.clock(clock),
			.wr_en(wr_en[i]),
			.wr_addr(wr_addr[i]),
			.wr_data(packetin_data[i]),
			.rd_addr(ram_rd_addr[i]),
			.rd_data(ram_rd_data[i])
		);

		cmd_queue #(
			.cmdq_depth(cmdq_depth)
		) u_cmdq (
			.clock(clock),
			.reset(reset),
			.push(q_push[i]),
			.push_cmd(push_cmd),
			.pop(q_pop[i]),
			.head(q_head[i]),
			.empty(q_empty[i]),
			.almost_full(q_afull[i])
		);

		egress_port u_egress (
			.clock(clock),
			.reset(reset),
			.head(q_head[i]),
			.empty(q_empty[i]),
			.pop(q_pop[i]),
			.rd_addr(eg_rd_addr[i]),
			.rd_src(eg_rd_src[i]),
			.rd_data(eg_rd_data[i]),
			.tx(tx_if)
		);
	end

endmodule

`default_nettype wire

//--- tb_pmem_group.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pmem_group import pmem_pkg::*;;

	// 60 packets of up to 20 words under random stalls take about a thousand cycles
	localparam int max_cycles = 20000;

	logic clock;
	logic reset;
	word_t in_data [num_ports];
	logic in_valid [num_ports];
	logic in_sop [num_ports];
	logic in_eop [num_ports];
	logic in_ready [num_ports];
	word_t out_data [num_ports];
	logic out_valid [num_ports];
	logic out_sop [num_ports];
	logic out_eop [num_ports];
	logic out_ready [num_ports];
	tag_t out_channel [num_ports];
	word_t tx_data [num_ports];
	logic tx_valid [num_ports];
	logic tx_sop [num_ports];
	logic tx_eop [num_ports];
	logic tx_ready [num_ports];
	match_t tag_data;
	logic tag_valid;
	logic tag_ready;

	int seed;
	int depth;
	int cycles;
	int checks_passed;
	int checks_failed;
	int test_errs [1:6];
	bit last_test;
	bit in_rand;
	bit tx_rand;
	bit match_en;
	bit match_gaps;
	bit hold_low [num_ports];
	int fixed_dst;
	int min_len;
	int max_len;
	int pkts_left [num_ports];
	int cur_len [num_ports];
	int cur_idx [num_ports];
	bit in_fire [num_ports];
	bit match_taken;
	int match_entry;
	int match_dst;
	int accepts;
	int stall_beats;

	// reference model with words per input and tag, expected packets per output
	int tag_count [num_ports];
	int widx [num_ports];
	word_t pkt_words [num_ports][64][20];
	int pkt_len [num_ports][64];
	int avail_q [$];
	int exp_q [num_ports][$];
	int rx_idx [num_ports];
	bit was_stalled [num_ports];
	word_t held_data [num_ports];
	logic held_sop [num_ports];
	logic held_eop [num_ports];

	pmem_group pmem_group_i (
		.clock(clock),
		.reset(reset),
		.packetin_data(in_data),
		.packetin_valid(in_valid),
		.packetin_sop(in_sop),
		.packetin_eop(in_eop),
		.packetin_ready(in_ready),
		.packetout_data(out_data),
		.packetout_valid(out_valid),
		.packetout_sop(out_sop),
		.packetout_eop(out_eop),
		.packetout_ready(out_ready),
		.packetout_channel(out_channel),
		.transmitout_data(tx_data),
		.transmitout_valid(tx_valid),
		.transmitout_sop(tx_sop),
		.transmitout_eop(tx_eop),
		.transmitout_ready(tx_ready),
		.tagin_data(tag_data),
		.tagin_valid(tag_valid),
		.tagin_ready(tag_ready)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// during the queue limit test every check counts towards it
	function automatic int id_of(input int n);
		return last_test ? 6 : n;
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1: return "reset";
			2: return "passthrough";
			3: return "replay";
			4: return "framing";
			5: return "back-pressure";
			default: return "queue limit";
		endcase
	endfunction

	task automatic check_value(input int id, input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s (%s): expected %h, actual %h", test_name(id), what, expected,
				actual);
			test_errs[id]++;
			checks_failed++;
		end else begin
			checks_passed++;
		end
	endtask

	task automatic finish_test(input int id);
		if (test_errs[id] == 0) begin
			$display("test %0d %s: ok", id, test_name(id));
		end else begin
			$display("test %0d %s: %0d errors", id, test_name(id), test_errs[id]);
		end
	endtask

	task automatic drive_input(input int i);
		// a presented beat stays until it transfers
		if (in_valid[i] && !in_fire[i]) begin
			return;
		end
		if (in_fire[i]) begin
			cur_idx[i]++;
			if (cur_idx[i] == cur_len[i]) begin
				cur_idx[i] = 0;
				cur_len[i] = 0;
			end
		end
		in_valid[i] = 1'b0;
		in_sop[i] = 1'b0;
		in_eop[i] = 1'b0;
		if (cur_len[i] == 0 && pkts_left[i] > 0) begin
			cur_len[i] = min_len + rnd(max_len - min_len + 1);
			pkts_left[i]--;
		end
		if (cur_len[i] != 0 && rnd(4) != 0) begin
			in_valid[i] = 1'b1;
			in_data[i] = {$random(seed), $random(seed)};
			in_sop[i] = (cur_idx[i] == 0);
			in_eop[i] = (cur_idx[i] == cur_len[i] - 1);
		end
	endtask

	task automatic drive_match();
		if (tag_valid && !match_taken) begin
			return;
		end
		tag_valid = 1'b0;
		if (match_en && avail_q.size() > 0 && (!match_gaps || rnd(4) != 0)) begin
			match_entry = avail_q.pop_front();
			match_dst = (fixed_dst >= 0) ? fixed_dst : rnd(num_ports);
			// destination, source, tag from the top bits down
			tag_data = {2'(match_dst), 2'(match_entry / 64), 6'(match_entry % 64)};
			tag_valid = 1'b1;
		end
	endtask

	always @(posedge clock) begin
		#1;
		if (!reset) begin
			for (int i = 0; i < num_ports; i++) begin
				drive_input(i);
				out_ready[i] = in_rand ? (rnd(4) != 0) : 1'b1;
				tx_ready[i] = hold_low[i] ? 1'b0 : (tx_rand ? (rnd(4) != 0) : 1'b1);
			end
			drive_match();
		end
	end

	task automatic watch_input(input int i);
		int t;
		check_value(id_of(2), "data", in_data[i], out_data[i]);
		check_value(id_of(2), "valid", 64'(in_valid[i]), 64'(out_valid[i]));
		check_value(id_of(2), "sop", 64'(in_sop[i]), 64'(out_sop[i]));
		check_value(id_of(2), "eop", 64'(in_eop[i]), 64'(out_eop[i]));
		check_value(id_of(2), "ready", 64'(out_ready[i]), 64'(in_ready[i]));
		check_value(id_of(2), "channel", 64'(tag_count[i] % 64), 64'(out_channel[i]));
		in_fire[i] = in_valid[i] && in_ready[i];
		if (in_fire[i]) begin
			t = tag_count[i] % 64;
			pkt_words[i][t][widx[i]] = in_data[i];
			widx[i]++;
			if (in_eop[i]) begin
				pkt_len[i][t] = widx[i];
				widx[i] = 0;
				avail_q.push_back(i * 64 + t);
				tag_count[i]++;
			end
		end
	endtask

	task automatic watch_output(input int o);
		int src;
		int t;
		int len;
		if (was_stalled[o]) begin
			check_value(id_of(5), "held valid", 64'(1), 64'(tx_valid[o]));
			check_value(id_of(5), "held data", held_data[o], tx_data[o]);
			check_value(id_of(5), "held sop", 64'(held_sop[o]), 64'(tx_sop[o]));
			check_value(id_of(5), "held eop", 64'(held_eop[o]), 64'(tx_eop[o]));
		end
		was_stalled[o] = tx_valid[o] && !tx_ready[o];
		if (was_stalled[o]) begin
			held_data[o] = tx_data[o];
			held_sop[o] = tx_sop[o];
			held_eop[o] = tx_eop[o];
			stall_beats++;
		end
		if (tx_valid[o] && tx_ready[o]) begin
			if (exp_q[o].size() == 0) begin
				$display("output %0d sent a beat while no packet was expected", o);
				test_errs[id_of(3)]++;
				checks_failed++;
			end else begin
				src = exp_q[o][0] / 64;
				t = exp_q[o][0] % 64;
				len = pkt_len[src][t];
				check_value(id_of(3), "data", pkt_words[src][t][rx_idx[o]], tx_data[o]);
				check_value(id_of(4), "sop", 64'(rx_idx[o] == 0), 64'(tx_sop[o]));
				check_value(id_of(4), "eop", 64'(rx_idx[o] == len - 1), 64'(tx_eop[o]));
				rx_idx[o]++;
				if (rx_idx[o] == len) begin
					rx_idx[o] = 0;
					void'(exp_q[o].pop_front());
				end
			end
		end
	endtask

	// a handshake seen mid-cycle transfers on the next rising edge
	always @(negedge clock) begin
		if (!reset) begin
			for (int i = 0; i < num_ports; i++) begin
				watch_input(i);
				watch_output(i);
			end
			match_taken = tag_valid && tag_ready;
			if (match_taken) begin
				exp_q[match_dst].push_back(match_entry);
				accepts++;
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic bit inputs_idle();
		for (int i = 0; i < num_ports; i++) begin
			if (pkts_left[i] != 0 || cur_len[i] != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	function automatic bit traffic_done();
		for (int o = 0; o < num_ports; o++) begin
			if (exp_q[o].size() != 0) begin
				return 1'b0;
			end
		end
		return inputs_idle() && avail_q.size() == 0 && !tag_valid;
	endfunction

	initial begin
		seed = 14027;
		reset = 1'b1;
		tag_data = '0;
		tag_valid = 1'b0;
		for (int i = 0; i < num_ports; i++) begin
			in_data[i] = '0;
			in_valid[i] = 1'b0;
			in_sop[i] = 1'b0;
			in_eop[i] = 1'b0;
			out_ready[i] = 1'b1;
			tx_ready[i] = 1'b1;
			hold_low[i] = 1'b0;
			pkts_left[i] = 0;
			cur_len[i] = 0;
			cur_idx[i] = 0;
			in_fire[i] = 1'b0;
			tag_count[i] = 0;
			widx[i] = 0;
			rx_idx[i] = 0;
			was_stalled[i] = 1'b0;
		end
		for (int id = 1; id <= 6; id++) begin
			test_errs[id] = 0;
		end
		cycles = 0;
		checks_passed = 0;
		checks_failed = 0;
		last_test = 1'b0;
		in_rand = 1'b0;
		tx_rand = 1'b0;
		match_en = 1'b0;
		match_gaps = 1'b1;
		fixed_dst = -1;
		min_len = 1;
		max_len = 20;
		match_taken = 1'b0;
		accepts = 0;
		stall_beats = 0;
		depth = pmem_group_i.cmdq_depth;

		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		@(negedge clock);
		for (int o = 0; o < num_ports; o++) begin
			check_value(1, "tx valid", 64'(0), 64'(tx_valid[o]));
			check_value(1, "tx sop", 64'(0), 64'(tx_sop[o]));
			check_value(1, "tx eop", 64'(0), 64'(tx_eop[o]));
		end
		check_value(1, "tag in ready", 64'(1), 64'(tag_ready));
		finish_test(1);

		// random traffic covers passthrough, replay, framing and back-pressure at once
		in_rand = 1'b1;
		tx_rand = 1'b1;
		match_en = 1'b1;
		for (int i = 0; i < num_ports; i++) begin
			pkts_left[i] = 15;
		end
		while (!traffic_done()) @(negedge clock);
		check_value(5, "stalls seen", 64'(1), 64'(stall_beats > 0));
		for (int id = 2; id <= 5; id++) begin
			finish_test(id);
		end

		// fill the buffers first, then offer matches without gaps to a stalled output
		last_test = 1'b1;
		match_en = 1'b0;
		match_gaps = 1'b0;
		min_len = 2;
		max_len = 12;
		for (int i = 0; i < num_ports; i++) begin
			pkts_left[i] = 6;
		end
		while (!inputs_idle()) @(negedge clock);
		repeat (2) @(negedge clock);
		hold_low[2] = 1'b1;
		fixed_dst = 2;
		accepts = 0;
		match_en = 1'b1;
		while (tag_ready) @(negedge clock);
		repeat (20) @(negedge clock);
		// depth-1 queued entries stop acceptance, one more sits in the match register
		// and the stalled egress already holds one
		check_value(6, "accepted while stalled", 64'(depth + 1), 64'(accepts));
		check_value(6, "tag in ready", 64'(0), 64'(tag_ready));
		hold_low[2] = 1'b0;
		while (!traffic_done()) @(negedge clock);
		finish_test(6);

		$display("checks passed %0d, failed %0d", checks_passed, checks_failed);
		if (checks_failed == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
pmem_pkg.sv
pkt_stream_if.sv
pkt_buffer_ram.sv
ingress_port.sv
cmd_queue.sv
egress_port.sv
pmem_group.sv
tb_pmem_group.sv

//--- Makefile
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing -Wno-fatal
TOP = tb_pmem_group
FILELIST = compile.f
OBJ_DIR = obj_dir
PASS_TEXT = All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
